/* project.f */
design/cdp_bufin_pkg.sv
design/cdp_bufin_input_stage.sv
design/cdp_bufin_fsm.sv
design/cdp_bufin_flush_cnt.sv
design/cdp_bufin_window.sv
design/cdp_bufin_top.sv
sim/tb_clk_gen.sv
sim/tb_cdp_bufin.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the channel-window buffer testbench with Verilator and runs it
# exit status is 0 only when the run reports a full pass

set -u

cd "$(dirname "$0")" || { echo "cannot enter the project root"; exit 1; }

verilator --binary --timing -sv --timescale 1ns/1ps \
  --top-module tb_cdp_bufin -Mdir obj_dir -o tb_sim -f project.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF 'All tests passed!'; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

/* sim/tb_cdp_bufin.sv */
// testbench for the channel-window buffer with TP 2 and ELEM_W 8
// each table row is one cube, rows are sent back to back
// expected words follow the centred window rule, zero outside groups 0..C-1
`timescale 1ns/1ps

module tb_cdp_bufin;

  localparam int TP       = 2;
  localparam int ELEM_W   = 8;
  localparam int BEAT_W   = TP * ELEM_W;
  localparam int HALF     = 4 / TP;
  localparam int OUT_W    = (2 * HALF + 1) * BEAT_W;
  localparam int NUM_ROWS = 7;
  localparam logic [7:0] SEED = 8'd226;

  // one cube: columns, groups, out_ready pattern, reuse data of the row before
  typedef struct packed {
    int         w;
    int         c;
    logic [7:0] mask;
    logic       reuse;
  } row_t;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      in_valid;
  logic                      in_ready;
  logic [BEAT_W-1:0]         in_data;
  cdp_bufin_pkg::pos_w_t     in_pos_w;
  cdp_bufin_pkg::width_t     in_width;
  cdp_bufin_pkg::pos_c_t     in_pos_c;
  logic                      in_last_c;
  logic                      out_valid;
  logic                      out_ready;
  logic [OUT_W-1:0]          out_data;
  cdp_bufin_pkg::beat_info_t out_info;

  row_t                      rows [NUM_ROWS];
  logic [BEAT_W-1:0]         cube_mem [cdp_bufin_pkg::NUM_COL][32];
  logic [7:0]                lfsr_q;
  logic [7:0]                cur_mask;
  bit                        table_loaded;
  int                        total_beats;
  int                        reset_err;
  // scoreboard, filled by the stimulus and drained by the monitor
  logic [OUT_W-1:0]          exp_data_q [$];
  cdp_bufin_pkg::beat_info_t exp_info_q [$];
  int                        exp_row_q [$];
  int                        exp_cnt [NUM_ROWS];
  int                        got_cnt [NUM_ROWS];
  int                        row_err [NUM_ROWS];
  int                        rows_done;
  int                        row_fail;
  int                        err_cnt;
  bit                        hold_pending;
  logic [OUT_W-1:0]          held_data;
  cdp_bufin_pkg::beat_info_t held_info;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) u_clk_gen (
    .nvdla_core_clk, .nvdla_core_rstn
  );

  cdp_bufin_top #(.TP(TP), .ELEM_W(ELEM_W)) DUT (
    .nvdla_core_clk, .nvdla_core_rstn,
    .in_valid, .in_ready, .in_data, .in_pos_w, .in_width, .in_pos_c, .in_last_c,
    .out_valid, .out_ready, .out_data, .out_info
  );

  //////////////////////////////////////////////////
  // stimulus data and reference rule
  //////////////////////////////////////////////////

  task automatic load_table();
    rows[0] = '{w: 4, c: 6, mask: 8'hFF, reuse: 1'b0};
    // same cube again under back-pressure
    rows[1] = '{w: 4, c: 6, mask: 8'hB2, reuse: 1'b1};
    rows[2] = '{w: 1, c: 2, mask: 8'hFF, reuse: 1'b0};
    rows[3] = '{w: 8, c: 2, mask: 8'h5A, reuse: 1'b0};
    rows[4] = '{w: 8, c: 7, mask: 8'hFF, reuse: 1'b0};
    rows[5] = '{w: 1, c: 3, mask: 8'h6D, reuse: 1'b0};
    rows[6] = '{w: 3, c: 9, mask: 8'hC6, reuse: 1'b0};
    total_beats = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_beats += rows[r].w * rows[r].c;
    end
  endtask

  // galois form, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // one lfsr step per data bit
  task automatic next_beat(output logic [BEAT_W-1:0] v);
    v = '0;
    for (int b = 0; b < BEAT_W; b++) begin
      v = {v[BEAT_W-2:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic fill_cube(input int ww, input int cc);
    logic [BEAT_W-1:0] v;
    for (int c = 0; c < cc; c++) begin
      for (int w = 0; w < ww; w++) begin
        next_beat(v);
        cube_mem[w][c] = v;
      end
    end
  endtask

  // groups outside the cube read as zero
  function automatic logic [BEAT_W-1:0] group_at(input int w, input int g, input int cc);
    if (g < 0 || g >= cc) begin
      return '0;
    end
    return cube_mem[w][g];
  endfunction

  // newest group k+HALF on top, down to k-HALF
  function automatic logic [OUT_W-1:0] expected_word(input int w, input int k, input int cc);
    logic [OUT_W-1:0] word;
    word = '0;
    for (int d = HALF; d >= -HALF; d--) begin
      word = {word[OUT_W-BEAT_W-1:0], group_at(w, k + d, cc)};
    end
    return word;
  endfunction

  task automatic queue_expected(input int r);
    cdp_bufin_pkg::beat_info_t info;
    int ww;
    int cc;
    ww = rows[r].w;
    cc = rows[r].c;
    exp_cnt[r] = ww * cc;
    for (int k = 0; k < cc; k++) begin
      for (int w = 0; w < ww; w++) begin
        info.pos_w    = cdp_bufin_pkg::pos_w_t'(w);
        info.width_m1 = cdp_bufin_pkg::width_t'(ww - 1);
        info.pos_c    = cdp_bufin_pkg::pos_c_t'(k);
        info.last_c   = (k == cc - 1);
        exp_data_q.push_back(expected_word(w, k, cc));
        exp_info_q.push_back(info);
        exp_row_q.push_back(r);
      end
    end
  endtask

  // drives right after a rising edge, returns after the accepting edge
  task automatic send_beat(input int w, input int c, input int ww, input int cc);
    bit accepted;
    in_valid  <= 1'b1;
    in_data   <= cube_mem[w][c];
    in_pos_w  <= cdp_bufin_pkg::pos_w_t'(w);
    in_width  <= cdp_bufin_pkg::width_t'(ww);
    in_pos_c  <= cdp_bufin_pkg::pos_c_t'(c);
    in_last_c <= (c == cc - 1);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge nvdla_core_clk);
      accepted = in_ready;
      @(posedge nvdla_core_clk);
    end
  endtask

  //////////////////////////////////////////////////
  // output monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  task automatic check_word();
    logic [OUT_W-1:0] exp_data;
    cdp_bufin_pkg::beat_info_t exp_info;
    int r;
    if (exp_data_q.size() == 0) begin
      $display("[ERROR] %0t unexpected output word %h", $time, out_data);
      err_cnt++;
    end else begin
      exp_data = exp_data_q.pop_front();
      exp_info = exp_info_q.pop_front();
      r        = exp_row_q.pop_front();
      if (out_data !== exp_data) begin
        $display("[ERROR] %0t row %0d k=%0d w=%0d data %h, expected %h", $time, r,
                 exp_info.pos_c, exp_info.pos_w, out_data, exp_data);
        err_cnt++;
        row_err[r]++;
      end
      if (out_info !== exp_info) begin
        $display("[ERROR] %0t row %0d info %h, expected %h", $time, r, out_info, exp_info);
        err_cnt++;
        row_err[r]++;
      end
      got_cnt[r]++;
      if (got_cnt[r] == exp_cnt[r]) begin
        $display("row %0d W=%0d C=%0d ready mask %b: %0d words, %s", r, rows[r].w,
                 rows[r].c, rows[r].mask, got_cnt[r], (row_err[r] == 0) ? "pass" : "FAIL");
        if (row_err[r] != 0) begin
          row_fail++;
        end
        rows_done++;
      end
    end
  endtask

  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      // a stalled word must stay in place
      if (hold_pending && (!out_valid || out_data !== held_data || out_info !== held_info)) begin
        $display("[ERROR] %0t stalled word changed or dropped: %h, held %h", $time,
                 out_data, held_data);
        err_cnt++;
        if (exp_row_q.size() != 0) begin
          row_err[exp_row_q[0]]++;
        end
      end
      hold_pending = out_valid && !out_ready;
      held_data    = out_data;
      held_info    = out_info;
      if (out_valid && out_ready) begin
        check_word();
      end
    end
  end

  // sink side, cycles through the row's ready pattern
  initial begin : ready_driver
    logic [2:0] idx;
    idx       = 3'd0;
    out_ready = 1'b1;
    forever begin
      @(posedge nvdla_core_clk);
      out_ready <= cur_mask[idx];
      idx = idx + 3'd1;
    end
  end

  //////////////////////////////////////////////////
  // main sequence and report
  //////////////////////////////////////////////////

  initial begin : stimulus
    int tests_failed;
    in_valid  = 1'b0;
    in_data   = '0;
    in_pos_w  = '0;
    in_width  = '0;
    in_pos_c  = '0;
    in_last_c = 1'b0;
    cur_mask  = 8'hFF;
    lfsr_q    = SEED;
    reset_err = 0;
    load_table();
    table_loaded = 1'b1;
    wait (nvdla_core_rstn === 1'b1);
    @(negedge nvdla_core_clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("[ERROR] %0t after reset out_valid=%b in_ready=%b, expected 0 and 1", $time,
               out_valid, in_ready);
      reset_err = 1;
    end
    $display("reset check: %s", (reset_err == 0) ? "pass" : "FAIL");
    @(posedge nvdla_core_clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (!rows[r].reuse) begin
        fill_cube(rows[r].w, rows[r].c);
      end
      queue_expected(r);
      cur_mask <= rows[r].mask;
      // group-major, column-minor
      for (int c = 0; c < rows[r].c; c++) begin
        for (int w = 0; w < rows[r].w; w++) begin
          send_beat(w, c, rows[r].w, rows[r].c);
        end
      end
    end
    in_valid <= 1'b0;
    wait (rows_done == NUM_ROWS);
    // idle window to catch stray words after the last cube
    repeat (20) @(posedge nvdla_core_clk);
    tests_failed = row_fail + reset_err;
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors", NUM_ROWS + 1,
             NUM_ROWS + 1 - tests_failed, tests_failed, err_cnt + reset_err);
    if (err_cnt == 0 && reset_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // limit scales with the beats in the table
  initial begin : watchdog
    wait (table_loaded);
    repeat (total_beats * 20) @(posedge nvdla_core_clk);
    $display("timeout: run did not finish within %0d cycles, %0d of %0d rows done",
             total_beats * 20, rows_done, NUM_ROWS);
    $display("Test failures found");
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
// clock and reset source for the testbench
// reset is low from time 0 and released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 2
) (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(PERIOD_NS / 2) nvdla_core_clk = ~nvdla_core_clk;
  end

  // release away from the rising edge so no flop sees it mid-update
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

/* design/cdp_bufin_top.sv */
// channel-window buffer for cross-channel normalization
// beats arrive group-major, column-minor; C must be at least 4/TP
// TP may be 1, 2 or 4
`timescale 1ns/1ps

module cdp_bufin_top #(
  parameter int TP     = 2,
  parameter int ELEM_W = 8
) (
  input  logic                                     nvdla_core_clk,
  input  logic                                     nvdla_core_rstn,
  input  logic                                     in_valid,
  output logic                                     in_ready,
  input  logic [TP*ELEM_W-1:0]                     in_data,
  input  cdp_bufin_pkg::pos_w_t                    in_pos_w,
  input  cdp_bufin_pkg::width_t                    in_width,
  input  cdp_bufin_pkg::pos_c_t                    in_pos_c,
  input  logic                                     in_last_c,
  output logic                                     out_valid,
  input  logic                                     out_ready,
  output logic [(2*(4/TP)+1)*TP*ELEM_W-1:0]        out_data,
  output cdp_bufin_pkg::beat_info_t                out_info
);

  localparam int BEAT_W = TP * ELEM_W;

  logic                      stage_valid;
  cdp_bufin_pkg::beat_info_t stage_info;
  logic [BEAT_W-1:0]         stage_data;
  cdp_bufin_pkg::beat_info_t flush_info;
  logic pop;
  logic shift_en;
  logic emit;
  logic zero_fill;
  logic cube_last;
  logic flush_step;
  logic clear;
  logic flush_done;
  logic out_free;

  // input register
  cdp_bufin_input_stage #(.TP(TP), .ELEM_W(ELEM_W)) u_input_stage (
    .nvdla_core_clk, .nvdla_core_rstn,
    .in_valid, .in_ready, .in_data, .in_pos_w, .in_width, .in_pos_c, .in_last_c,
    .pop, .stage_valid, .stage_info, .stage_data
  );

  // control
  cdp_bufin_fsm #(.TP(TP)) u_fsm (
    .nvdla_core_clk, .nvdla_core_rstn,
    .stage_valid, .stage_info, .out_free, .flush_done,
    .pop, .shift_en, .emit, .zero_fill, .cube_last, .flush_step, .clear
  );

  // cube-end flush sequencing
  cdp_bufin_flush_cnt #(.TP(TP)) u_flush_cnt (
    .nvdla_core_clk, .nvdla_core_rstn,
    .cube_last, .stage_info, .flush_step, .clear, .flush_info, .flush_done
  );

  // windows and output register
  cdp_bufin_window #(.TP(TP), .ELEM_W(ELEM_W)) u_window (
    .nvdla_core_clk, .nvdla_core_rstn,
    .shift_en, .emit, .zero_fill, .stage_info, .stage_data, .flush_info,
    .out_free, .out_valid, .out_ready, .out_data, .out_info
  );

endmodule

/* design/cdp_bufin_window.sv */
// per-column shift windows and the output register
// slot 0 holds the newest group, the last slot the oldest
// a beat with pos_c 0 clears the history of its column
`timescale 1ns/1ps

module cdp_bufin_window #(
  parameter int TP     = 2,
  parameter int ELEM_W = 8
) (
  input  logic                                             nvdla_core_clk,
  input  logic                                             nvdla_core_rstn,
  input  logic                                             shift_en,
  input  logic                                             emit,
  input  logic                                             zero_fill,
  input  cdp_bufin_pkg::beat_info_t                        stage_info,
  input  logic [TP*ELEM_W-1:0]                             stage_data,
  input  cdp_bufin_pkg::beat_info_t                        flush_info,
  output logic                                             out_free,
  output logic                                             out_valid,
  input  logic                                             out_ready,
  output logic [(2*(4/TP)+1)*TP*ELEM_W-1:0]                out_data,
  output cdp_bufin_pkg::beat_info_t                        out_info
);

  localparam int BEAT_W      = TP * ELEM_W;
  localparam int FILL_GROUPS = 4 / TP;
  localparam int WIN_BEATS   = 2 * FILL_GROUPS + 1;
  localparam int OUT_W       = WIN_BEATS * BEAT_W;
  localparam int COL_AW      = $clog2(cdp_bufin_pkg::NUM_COL);

  logic [BEAT_W-1:0] win_q [cdp_bufin_pkg::NUM_COL][WIN_BEATS-1];
  logic [COL_AW-1:0] col_idx;
  logic [BEAT_W-1:0] new_beat;
  logic              hist_clr;
  logic [OUT_W-1:0]  out_word;
  cdp_bufin_pkg::beat_info_t info_nxt;

  //////////////////////////////////////////////////
  // column select and incoming group
  //////////////////////////////////////////////////

  // flush walks the columns by its own counter
  assign col_idx  = zero_fill ? flush_info.pos_w[COL_AW-1:0] : stage_info.pos_w[COL_AW-1:0];
  assign new_beat = zero_fill ? '0 : stage_data;
  // first group of a cube, nothing older exists
  assign hist_clr = ~zero_fill & (stage_info.pos_c == '0);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      for (int c = 0; c < cdp_bufin_pkg::NUM_COL; c++) begin
        for (int s = 0; s < WIN_BEATS - 1; s++) begin
          win_q[c][s] <= '0;
        end
      end
    end else if (shift_en) begin
      win_q[col_idx][0] <= new_beat;
      for (int s = 1; s < WIN_BEATS - 1; s++) begin
        win_q[col_idx][s] <= hist_clr ? '0 : win_q[col_idx][s-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // output word and info
  //////////////////////////////////////////////////

  // newest group on top, then the window slots down to the oldest
  always_comb begin
    out_word[OUT_W-1 -: BEAT_W] = new_beat;
    for (int s = 0; s < WIN_BEATS - 1; s++) begin
      out_word[(WIN_BEATS-2-s)*BEAT_W +: BEAT_W] = win_q[col_idx][s];
    end
  end

  // streamed words are centred FILL_GROUPS behind the incoming beat
  always_comb begin
    if (zero_fill) begin
      info_nxt = flush_info;
    end else begin
      info_nxt        = stage_info;
      info_nxt.pos_c  = stage_info.pos_c - cdp_bufin_pkg::pos_c_t'(FILL_GROUPS);
      info_nxt.last_c = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  assign out_free = ~out_valid | out_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
    end else if (emit) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // word stays put while the sink stalls
  always_ff @(posedge nvdla_core_clk) begin
    if (emit) begin
      out_data <= out_word;
      out_info <= info_nxt;
    end
  end

endmodule

/* design/cdp_bufin_flush_cnt.sv */
// geometry latch and column/group counter for the cube-end flush
// flush runs FILL_GROUPS rounds over all columns, column index fastest
`timescale 1ns/1ps

module cdp_bufin_flush_cnt #(
  parameter int TP = 2
) (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      cube_last,
  input  cdp_bufin_pkg::beat_info_t stage_info,
  input  logic                      flush_step,
  input  logic                      clear,
  output cdp_bufin_pkg::beat_info_t flush_info,
  output logic                      flush_done
);

  localparam int FILL_GROUPS = 4 / TP;

  cdp_bufin_pkg::width_t lat_width_m1;
  cdp_bufin_pkg::pos_c_t lat_last_c;
  cdp_bufin_pkg::pos_w_t col_cnt;
  cdp_bufin_pkg::pos_c_t grp_cnt;
  logic col_end;
  logic grp_end;

  assign col_end    = (col_cnt == lat_width_m1);
  assign grp_end    = (grp_cnt == cdp_bufin_pkg::pos_c_t'(FILL_GROUPS - 1));
  assign flush_done = col_end & grp_end;

  // geometry of the cube, taken from its final beat
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      lat_width_m1 <= '0;
      lat_last_c   <= '0;
    end else if (cube_last) begin
      lat_width_m1 <= stage_info.width_m1;
      lat_last_c   <= stage_info.pos_c;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      col_cnt <= '0;
      grp_cnt <= '0;
    end else if (clear) begin
      col_cnt <= '0;
      grp_cnt <= '0;
    end else if (flush_step) begin
      if (col_end) begin
        col_cnt <= '0;
        grp_cnt <= grp_cnt + cdp_bufin_pkg::pos_c_t'(1);
      end else begin
        col_cnt <= col_cnt + cdp_bufin_pkg::pos_w_t'(1);
      end
    end
  end

  // centre group of the flush word walks up to the last group
  always_comb begin
    flush_info.pos_w    = col_cnt;
    flush_info.width_m1 = lat_width_m1;
    flush_info.pos_c    = lat_last_c - cdp_bufin_pkg::pos_c_t'(FILL_GROUPS - 1) + grp_cnt;
    flush_info.last_c   = grp_end;
  end

endmodule

/* design/cdp_bufin_fsm.sv */
// control for one cube: fill the windows, stream words, then flush
// every pop and flush step waits for a free output register
`timescale 1ns/1ps

module cdp_bufin_fsm #(
  parameter int TP = 2
) (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      stage_valid,
  input  cdp_bufin_pkg::beat_info_t stage_info,
  input  logic                      out_free,
  input  logic                      flush_done,
  output logic                      pop,
  output logic                      shift_en,
  output logic                      emit,
  output logic                      zero_fill,
  output logic                      cube_last,
  output logic                      flush_step,
  output logic                      clear
);

  localparam int FILL_GROUPS = 4 / TP;

  cdp_bufin_pkg::bufin_state_e state_q;
  cdp_bufin_pkg::bufin_state_e state_d;
  logic pop_ok;
  logic row_end;
  logic fill_end;

  assign pop_ok   = stage_valid & out_free;
  // last column of the current group
  assign row_end  = (stage_info.pos_w == stage_info.width_m1);
  // last beat before the first centred word can be formed
  assign fill_end = row_end &
                    (stage_info.pos_c == cdp_bufin_pkg::pos_c_t'(FILL_GROUPS - 1));

  always_comb begin
    state_d    = state_q;
    pop        = 1'b0;
    shift_en   = 1'b0;
    emit       = 1'b0;
    zero_fill  = 1'b0;
    cube_last  = 1'b0;
    flush_step = 1'b0;
    clear      = 1'b0;
    case (state_q)
      // wait and fill share the exit check, a one-group fill ends on the first beat
      cdp_bufin_pkg::ST_WAIT, cdp_bufin_pkg::ST_FILL: begin
        pop      = pop_ok;
        shift_en = pop_ok;
        if (pop_ok) begin
          if (fill_end) begin
            cube_last = 1'b1;
            state_d   = stage_info.last_c ? cdp_bufin_pkg::ST_FLUSH : cdp_bufin_pkg::ST_STREAM;
          end else begin
            state_d = cdp_bufin_pkg::ST_FILL;
          end
        end
      end
      cdp_bufin_pkg::ST_STREAM: begin
        pop      = pop_ok;
        shift_en = pop_ok;
        emit     = pop_ok;
        if (pop_ok & stage_info.last_c & row_end) begin
          cube_last = 1'b1;
          state_d   = cdp_bufin_pkg::ST_FLUSH;
        end
      end
      // push zero groups through every column, input stays blocked
      cdp_bufin_pkg::ST_FLUSH: begin
        flush_step = out_free;
        emit       = out_free;
        zero_fill  = out_free;
        shift_en   = out_free;
        if (out_free & flush_done) begin
          state_d = cdp_bufin_pkg::ST_DONE;
        end
      end
      cdp_bufin_pkg::ST_DONE: begin
        clear   = 1'b1;
        state_d = cdp_bufin_pkg::ST_WAIT;
      end
      default: begin
        state_d = cdp_bufin_pkg::ST_WAIT;
      end
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state_q <= cdp_bufin_pkg::ST_WAIT;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* design/cdp_bufin_input_stage.sv */
// one-deep input register between the source and the window
// in_width arrives as a count of 1..8 and is held as count minus one
`timescale 1ns/1ps

module cdp_bufin_input_stage #(
  parameter int TP     = 2,
  parameter int ELEM_W = 8
) (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [TP*ELEM_W-1:0]      in_data,
  input  cdp_bufin_pkg::pos_w_t     in_pos_w,
  input  cdp_bufin_pkg::width_t     in_width,
  input  cdp_bufin_pkg::pos_c_t     in_pos_c,
  input  logic                      in_last_c,
  input  logic                      pop,
  output logic                      stage_valid,
  output cdp_bufin_pkg::beat_info_t stage_info,
  output logic [TP*ELEM_W-1:0]      stage_data
);

  localparam int BEAT_W = TP * ELEM_W;

  logic take;

  // free slot, or the held beat leaves this cycle
  assign in_ready = ~stage_valid | pop;
  assign take     = in_valid & in_ready;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stage_valid <= 1'b0;
    end else if (take) begin
      stage_valid <= 1'b1;
    end else if (pop) begin
      stage_valid <= 1'b0;
    end
  end

  // payload, qualified by stage_valid
  always_ff @(posedge nvdla_core_clk) begin
    if (take) begin
      stage_data          <= in_data[BEAT_W-1:0];
      stage_info.pos_w    <= in_pos_w;
      stage_info.width_m1 <= in_width - cdp_bufin_pkg::width_t'(1);
      stage_info.pos_c    <= in_pos_c;
      stage_info.last_c   <= in_last_c;
    end
  end

endmodule

/* design/cdp_bufin_pkg.sv */
// shared field types for the channel-window buffer
// a cube is one line of up to 8 columns by up to 32 channel groups
// widths here are fixed; beat width comes from the top level parameters

package cdp_bufin_pkg;

  //////////////////////////////////////////////////
  // field widths
  //////////////////////////////////////////////////

  // width column index, only 0..7 are used
  typedef logic [3:0] pos_w_t;

  // column count minus one
  typedef logic [3:0] width_t;

  // channel group index within the cube
  typedef logic [4:0] pos_c_t;

  // number of per-column windows kept in the buffer
  localparam int NUM_COL = 8;

  //////////////////////////////////////////////////
  // beat information, 14 bits
  //////////////////////////////////////////////////
  typedef struct packed {
    pos_w_t pos_w;
    width_t width_m1;
    pos_c_t pos_c;
    // beat belongs to the last group of the cube
    logic   last_c;
  } beat_info_t;

  //////////////////////////////////////////////////
  // control states
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ST_WAIT   = 3'd0,
    ST_FILL   = 3'd1,
    ST_STREAM = 3'd2,
    ST_FLUSH  = 3'd3,
    ST_DONE   = 3'd4
  } bufin_state_e;

endpackage
